/* source/lsuCfgPkg.sv */
package lsuCfgPkg;

  ////////////////////////////////////////
  // Default sizes
  ////////////////////////////////////////

  localparam int XlenDefault = 64;                                    // Data and address width
  localparam int DtimDepthDefault = 256;                              // Xlen-wide words in DTIM
  localparam logic [63:0] DtimBaseDefault = 64'h0000_0000_8000_0000;  // Byte base of DTIM

  ////////////////////////////////////////
  // Derived widths
  ////////////////////////////////////////

  // Low address bits that pick a byte lane inside one word
  function automatic int byteOffW(int xlen);
    return $clog2(xlen / 8);
  endfunction

  function automatic int idxW(int depth);  // DTIM word index width
    return $clog2(depth);
  endfunction

  function automatic longint windowBytes(int xlen, int depth);  // Size of DTIM window in bytes
    return longint'(depth) * longint'(xlen / 8);
  endfunction

endpackage

/* source/lsuOpPkg.sv */
package lsuOpPkg;

  ////////////////////////////////////////
  // Operation encodings
  ////////////////////////////////////////

  // Read/write code, same bit order as MemRW in the pipeline
  typedef enum logic [1:0] {
    MemIdle  = 2'b00,
    MemWrite = 2'b01,   // Bit 0 is the write request
    MemRead  = 2'b10    // Bit 1 is the read request
  } memRwT;

  // Access size, funct3[1:0]
  typedef enum logic [1:0] {
    SizeByte   = 2'd0,
    SizeHalf   = 2'd1,
    SizeWord   = 2'd2,
    SizeDouble = 2'd3
  } sizeT;

  ////////////////////////////////////////
  // Control and fault bundles
  ////////////////////////////////////////

  typedef struct packed {
    memRwT rw;             // Idle, read or write
    sizeT  size;           // Byte, half, word, double
    logic  unsignedLoad;   // funct3[2], zero-extend on load
    logic  bigEndian;      // Swap byte order to and from memory
  } memOpT;

  // Memory-stage exceptions, at most one high at a time
  typedef struct packed {
    logic loadMisaligned;
    logic storeMisaligned;
    logic loadAccess;      // Aligned load outside DTIM window
    logic storeAccess;     // Aligned store outside DTIM window
  } lsuFaultT;

endpackage

/* source/addrStage.sv */
module addrStage #(
  parameter int Xlen = lsuCfgPkg::XlenDefault,
  parameter int DtimDepth = lsuCfgPkg::DtimDepthDefault,
  parameter logic [Xlen-1:0] DtimBase = Xlen'(lsuCfgPkg::DtimBaseDefault)
) (
  input  logic                                  clk, rstN,
  input  logic                                  StallM, FlushM,
  input  logic [Xlen-1:0]                       IEUAdrE,
  input  lsuOpPkg::memOpT                       MemOpM,
  output logic [Xlen-1:0]                       IEUAdrM,
  output logic [lsuCfgPkg::idxW(DtimDepth)-1:0] DtimIdxM,
  output lsuOpPkg::lsuFaultT                    FaultM
);
  localparam int ByteOffW = lsuCfgPkg::byteOffW(Xlen);
  localparam int IdxW = lsuCfgPkg::idxW(DtimDepth);
  localparam logic [Xlen-1:0] WinBytes = Xlen'(lsuCfgPkg::windowBytes(Xlen, DtimDepth));

  logic [Xlen-1:0] OffsetM;      // Byte offset from DTIM base, wraps below base
  logic            OutOfRange;
  logic            Misaligned;
  logic            IsLoad, IsStore;

  // E to M address register, flush loads zero
  always_ff @(posedge clk) begin
    if (!rstN) IEUAdrM <= '0;
    else if (!StallM) IEUAdrM <= FlushM ? '0 : IEUAdrE;
  end

  ////////////////////////////////////////
  // Alignment and range
  ////////////////////////////////////////

  always_comb begin
    case (MemOpM.size)
      lsuOpPkg::SizeByte: Misaligned = 1'b0;           // Bytes never misalign
      lsuOpPkg::SizeHalf: Misaligned = IEUAdrM[0];
      lsuOpPkg::SizeWord: Misaligned = |IEUAdrM[1:0];
      default:            Misaligned = |IEUAdrM[2:0];  // Double
    endcase
  end

  assign OffsetM = IEUAdrM - DtimBase;
  assign OutOfRange = (OffsetM >= WinBytes);  // Below base also lands here by wraparound
  assign DtimIdxM = OffsetM[IdxW+ByteOffW-1:ByteOffW];

  assign IsLoad = (MemOpM.rw == lsuOpPkg::MemRead);
  assign IsStore = (MemOpM.rw == lsuOpPkg::MemWrite);

  // Misalignment wins over access fault
  assign FaultM.loadMisaligned = IsLoad & Misaligned;
  assign FaultM.storeMisaligned = IsStore & Misaligned;
  assign FaultM.loadAccess = IsLoad & ~Misaligned & OutOfRange;
  assign FaultM.storeAccess = IsStore & ~Misaligned & OutOfRange;

endmodule

/* source/storeFormat.sv */
module storeFormat #(
  parameter int Xlen = lsuCfgPkg::XlenDefault
) (
  input  lsuOpPkg::memOpT                    MemOpM,
  input  logic [lsuCfgPkg::byteOffW(Xlen)-1:0] ByteOffM,    // Low address bits
  input  logic [Xlen-1:0]                    WriteDataM,
  output logic [Xlen-1:0]                    DtimWrData,
  output logic [Xlen/8-1:0]                  DtimByteEn
);
  localparam int ByteW = Xlen / 8;  // Byte lanes per word

  logic [Xlen-1:0]  ReplData;     // Subword copied to every lane
  logic [Xlen-1:0]  SwappedData;
  logic [ByteW-1:0] SizeMask;     // Lanes covered at offset zero
  logic [ByteW-1:0] LeByteEn;
  logic [ByteW-1:0] SwappedByteEn;

  ////////////////////////////////////////
  // Replicate and mask
  ////////////////////////////////////////

  always_comb begin
    case (MemOpM.size)
      lsuOpPkg::SizeByte: begin
        ReplData = {ByteW{WriteDataM[7:0]}};
        SizeMask = ByteW'(8'h01);
      end
      lsuOpPkg::SizeHalf: begin
        ReplData = {(ByteW/2){WriteDataM[15:0]}};
        SizeMask = ByteW'(8'h03);
      end
      lsuOpPkg::SizeWord: begin
        ReplData = {(ByteW/4){WriteDataM[31:0]}};
        SizeMask = ByteW'(8'h0f);
      end
      default: begin
        ReplData = WriteDataM;       // Full word, nothing to copy
        SizeMask = '1;
      end
    endcase
  end

  assign LeByteEn = SizeMask << ByteOffM;

  // Big-endian image, lanes mirrored along with the data
  assign SwappedData = {<<8{ReplData}};
  assign SwappedByteEn = {<<{LeByteEn}};

  assign DtimWrData = MemOpM.bigEndian ? SwappedData : ReplData;
  assign DtimByteEn = MemOpM.bigEndian ? SwappedByteEn : LeByteEn;

endmodule

/* source/dtim.sv */
module dtim #(
  parameter int Xlen = lsuCfgPkg::XlenDefault,
  parameter int DtimDepth = lsuCfgPkg::DtimDepthDefault
) (
  input  logic                                  clk,
  input  logic                                  StallW, FlushW,
  input  lsuOpPkg::memOpT                       MemOpM,
  input  lsuOpPkg::lsuFaultT                    FaultM,
  input  logic [lsuCfgPkg::idxW(DtimDepth)-1:0] DtimIdxM,
  input  logic [Xlen-1:0]                       DtimWrData,
  input  logic [Xlen/8-1:0]                     DtimByteEn,
  output logic [Xlen-1:0]                       DtimRdData
);
  localparam int ByteW = Xlen / 8;

  logic [Xlen-1:0] Mem [DtimDepth];  // Word array, contents undefined at start
  logic            StoreFault;
  logic            WriteEn;

  ////////////////////////////////////////
  // Write enable
  ////////////////////////////////////////

  assign StoreFault = FaultM.storeMisaligned | FaultM.storeAccess;
  assign WriteEn = (MemOpM.rw == lsuOpPkg::MemWrite) & ~StoreFault
                 & ~FlushW & ~StallW;   // Store retires only when W advances

  // Byte-lane write at the edge ending M
  always_ff @(posedge clk) begin
    if (WriteEn) begin
      for (int b = 0; b < ByteW; b++) begin
        if (DtimByteEn[b]) Mem[DtimIdxM][b*8 +: 8] <= DtimWrData[b*8 +: 8];
      end
    end
  end

  // Asynchronous read at M address
  assign DtimRdData = Mem[DtimIdxM];

endmodule

/* source/loadFormat.sv */
module loadFormat #(
  parameter int Xlen = lsuCfgPkg::XlenDefault
) (
  input  logic                                 clk, rstN,
  input  logic                                 StallW,
  input  lsuOpPkg::memOpT                      MemOpM,
  input  logic [lsuCfgPkg::byteOffW(Xlen)-1:0] ByteOffM,
  input  logic [Xlen-1:0]                      DtimRdData,
  output logic [Xlen-1:0]                      ReadDataW
);
  logic [Xlen-1:0] SwappedRdData;
  logic [Xlen-1:0] LeRdData;       // Little-endian view of the word
  logic [Xlen-1:0] ShiftedRdData;  // Addressed subword in low lanes
  logic [Xlen-1:0] ReadDataM;      // Extended load value

  ////////////////////////////////////////
  // Endian swap and lane select
  ////////////////////////////////////////

  assign SwappedRdData = {<<8{DtimRdData}};
  assign LeRdData = MemOpM.bigEndian ? SwappedRdData : DtimRdData;
  assign ShiftedRdData = LeRdData >> {ByteOffM, 3'b000};  // Offset in bytes to bits

  // Sign or zero extension by size
  always_comb begin
    case (MemOpM.size)
      lsuOpPkg::SizeByte: begin
        if (MemOpM.unsignedLoad) ReadDataM = Xlen'(ShiftedRdData[7:0]);
        else ReadDataM = Xlen'(signed'(ShiftedRdData[7:0]));
      end
      lsuOpPkg::SizeHalf: begin
        if (MemOpM.unsignedLoad) ReadDataM = Xlen'(ShiftedRdData[15:0]);
        else ReadDataM = Xlen'(signed'(ShiftedRdData[15:0]));
      end
      lsuOpPkg::SizeWord: begin
        // lwu vs lw on 64-bit
        if (MemOpM.unsignedLoad) ReadDataM = Xlen'(ShiftedRdData[31:0]);
        else ReadDataM = Xlen'(signed'(ShiftedRdData[31:0]));
      end
      default: ReadDataM = ShiftedRdData;  // Double fills the word
    endcase
  end

  ////////////////////////////////////////
  // M to W register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) ReadDataW <= '0;
    else if (!StallW) ReadDataW <= ReadDataM;   // Holds while W stalls
  end

endmodule

/* source/lsu.sv */
module lsu #(
  parameter int Xlen = lsuCfgPkg::XlenDefault,
  parameter int DtimDepth = lsuCfgPkg::DtimDepthDefault,
  parameter logic [Xlen-1:0] DtimBase = Xlen'(lsuCfgPkg::DtimBaseDefault)
) (
  input  logic                 clk, rstN,
  input  logic                 StallM, FlushM, StallW, FlushW,  // Hazard unit levels
  input  logic [Xlen-1:0]      IEUAdrE,                         // Execute stage address
  input  lsuOpPkg::memOpT      MemOpM,                          // Memory stage operation
  input  logic [Xlen-1:0]      WriteDataM,                      // Store data from IEU
  output logic [Xlen-1:0]      IEUAdrM,                         // Memory stage address
  output lsuOpPkg::lsuFaultT   FaultM,                          // Combinational faults in M
  output logic [Xlen-1:0]      ReadDataW                        // Load result to writeback
);
  localparam int ByteOffW = lsuCfgPkg::byteOffW(Xlen);
  localparam int IdxW = lsuCfgPkg::idxW(DtimDepth);

  logic [IdxW-1:0]   DtimIdxM;     // Word index inside DTIM
  logic [Xlen-1:0]   DtimWrData;   // Replicated, swapped store word
  logic [Xlen/8-1:0] DtimByteEn;   // Byte lanes to write
  logic [Xlen-1:0]   DtimRdData;   // Raw word at DtimIdxM

  ////////////////////////////////////////
  // E to M address and fault checks
  ////////////////////////////////////////

  addrStage #(.Xlen(Xlen), .DtimDepth(DtimDepth), .DtimBase(DtimBase)) addrStage (
    .clk, .rstN, .StallM, .FlushM, .IEUAdrE, .MemOpM,
    .IEUAdrM, .DtimIdxM, .FaultM
  );

  ////////////////////////////////////////
  // Store path into DTIM
  ////////////////////////////////////////

  storeFormat #(.Xlen(Xlen)) storeFormat (
    .MemOpM, .ByteOffM(IEUAdrM[ByteOffW-1:0]), .WriteDataM,
    .DtimWrData, .DtimByteEn
  );

  dtim #(.Xlen(Xlen), .DtimDepth(DtimDepth)) dtim (
    .clk, .StallW, .FlushW, .MemOpM, .FaultM, .DtimIdxM,
    .DtimWrData, .DtimByteEn, .DtimRdData
  );

  // Load path and M to W register
  loadFormat #(.Xlen(Xlen)) loadFormat (
    .clk, .rstN, .StallW, .MemOpM, .ByteOffM(IEUAdrM[ByteOffW-1:0]),
    .DtimRdData, .ReadDataW
  );

endmodule

/* test/lsu_checker.sv */
module lsuChecker #(
  parameter int Xlen = lsuCfgPkg::XlenDefault
) (
  input logic               clk, rstN,
  input logic               StallW,
  input lsuOpPkg::memOpT    MemOpM,
  input lsuOpPkg::lsuFaultT FaultM,
  input logic [Xlen-1:0]    ReadDataW
);

  ////////////////////////////////////////
  // Fault rules
  ////////////////////////////////////////

  // Load faults need a load in M
  loadFaultNeedsRead: assert property (@(posedge clk) disable iff (!rstN)
    (MemOpM.rw != lsuOpPkg::MemRead) |-> !(FaultM.loadMisaligned || FaultM.loadAccess))
    else $error("load fault raised while rw is not a read");

  faultOneHot: assert property (@(posedge clk) disable iff (!rstN)
    $onehot0(FaultM))               // Misaligned masks access fault
    else $error("more than one fault bit high");

  ////////////////////////////////////////
  // W register
  ////////////////////////////////////////

  readHoldOnStall: assert property (@(posedge clk) disable iff (!rstN)
    StallW |=> $stable(ReadDataW))
    else $error("ReadDataW changed while StallW was high");

endmodule

bind lsu lsuChecker #(.Xlen(Xlen)) lsuCheck (
  .clk, .rstN, .StallW, .MemOpM, .FaultM, .ReadDataW
);

/* test/lsuTb.sv */
module lsuTb;
  localparam int Xlen = lsuCfgPkg::XlenDefault;
  localparam int Period = 40;
  localparam int NumRandom = 200;
  localparam logic [63:0] Base = lsuCfgPkg::DtimBaseDefault;
  localparam lsuOpPkg::memRwT St = lsuOpPkg::MemWrite;
  localparam lsuOpPkg::memRwT Ld = lsuOpPkg::MemRead;

  // One table row
  typedef struct packed {
    logic [63:0]        adr;
    lsuOpPkg::memOpT    op;
    logic [63:0]        wd;
    logic [3:0]         ctl;       // {StallM, FlushM, FlushW, StallW}
    lsuOpPkg::lsuFaultT expFault;  // {loadMis, storeMis, loadAcc, storeAcc}
    logic               chkRd;
    logic [63:0]        expRd;
  } rowT;

  logic               clk = 1'b0;
  logic               rstN, StallM, FlushM, StallW, FlushW;
  logic [Xlen-1:0]    IEUAdrE, WriteDataM, IEUAdrM, ReadDataW;
  lsuOpPkg::memOpT    MemOpM;
  lsuOpPkg::lsuFaultT FaultM;
  rowT                rows[$];
  logic [7:0]         model [64];  // Bytes of the first 8 DTIM words
  logic [31:0]        seed = 32'he47a3171;
  int                 errCount = 0;
  int                 passCount = 0;
  int                 failCount = 0;

  lsu #(.Xlen(Xlen), .DtimDepth(lsuCfgPkg::DtimDepthDefault), .DtimBase(Base)) i_lsu (.*);

  always #(Period / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic lsuOpPkg::memOpT makeOp(lsuOpPkg::memRwT rw, int size, int uns, int be);
    lsuOpPkg::memOpT op;
    op.rw = rw;
    op.size = lsuOpPkg::sizeT'(size[1:0]);  // 0 byte .. 3 double
    op.unsignedLoad = (uns != 0);
    op.bigEndian = (be != 0);
    return op;
  endfunction

  task automatic addRow(logic [63:0] adr, lsuOpPkg::memOpT op, logic [63:0] wd, int ctl,
                        int flt, int chk, logic [63:0] rd);
    rowT r;
    r = '{adr, op, wd, 4'(ctl), lsuOpPkg::lsuFaultT'(4'(flt)), chk != 0, rd};
    rows.push_back(r);
  endtask

  ////////////////////////////////////////
  // Directed table
  ////////////////////////////////////////

  task automatic buildTable();
    addRow(Base + 'h000, makeOp(St, 3, 0, 0), 64'h0123_4567_89ab_cdef, 0, 0, 0, 0);
    addRow(Base + 'h000, makeOp(Ld, 3, 0, 0), 0, 0, 0, 1, 64'h0123_4567_89ab_cdef);
    addRow(Base + 'h001, makeOp(Ld, 0, 0, 0), 0, 0, 0, 1, 64'hffff_ffff_ffff_ffcd);
    addRow(Base + 'h007, makeOp(Ld, 0, 1, 0), 0, 0, 0, 1, 64'h0000_0000_0000_0001);
    addRow(Base + 'h002, makeOp(Ld, 1, 1, 0), 0, 0, 0, 1, 64'h0000_0000_0000_89ab);
    addRow(Base + 'h000, makeOp(Ld, 2, 0, 0), 0, 0, 0, 1, 64'hffff_ffff_89ab_cdef);
    addRow(Base + 'h004, makeOp(Ld, 2, 1, 0), 0, 0, 0, 1, 64'h0000_0000_0123_4567);
    addRow(Base + 'h003, makeOp(St, 0, 0, 0), 64'h5a, 0, 0, 0, 0);
    addRow(Base + 'h004, makeOp(St, 1, 0, 0), 64'hbeef, 0, 0, 0, 0);
    addRow(Base + 'h000, makeOp(Ld, 3, 0, 0), 0, 0, 0, 1, 64'h0123_beef_5aab_cdef);
    // Big-endian images in word 1
    addRow(Base + 'h008, makeOp(St, 3, 0, 1), 64'h1122_3344_5566_7788, 0, 0, 0, 0);
    addRow(Base + 'h008, makeOp(Ld, 3, 0, 1), 0, 0, 0, 1, 64'h1122_3344_5566_7788);
    addRow(Base + 'h008, makeOp(Ld, 3, 0, 0), 0, 0, 0, 1, 64'h8877_6655_4433_2211);
    addRow(Base + 'h008, makeOp(St, 2, 0, 1), 64'hdead_beef, 0, 0, 0, 0);
    addRow(Base + 'h008, makeOp(Ld, 2, 1, 1), 0, 0, 0, 1, 64'h0000_0000_dead_beef);
    addRow(Base + 'h00a, makeOp(Ld, 1, 0, 1), 0, 0, 0, 1, 64'hffff_ffff_ffff_dead);
    // Misaligned accesses leave word 0 unchanged
    addRow(Base + 'h001, makeOp(St, 1, 0, 0), 64'hffff, 0, 'h4, 0, 0);
    addRow(Base + 'h002, makeOp(Ld, 2, 0, 0), 0, 0, 'h8, 0, 0);
    addRow(Base + 'h004, makeOp(St, 3, 0, 0), '1, 0, 'h4, 0, 0);
    addRow(Base + 'h000, makeOp(Ld, 3, 0, 0), 0, 0, 0, 1, 64'h0123_beef_5aab_cdef);
    // Below the base aliases word 255 and past the window aliases word 0
    addRow(Base + 'h7f8, makeOp(St, 3, 0, 0), 64'hcafe_f00d_1234_5678, 0, 0, 0, 0);
    addRow(Base - 'h008, makeOp(St, 3, 0, 0), 0, 0, 'h1, 0, 0);
    addRow(Base + 'h7f8, makeOp(Ld, 3, 0, 0), 0, 0, 0, 1, 64'hcafe_f00d_1234_5678);
    addRow(Base + 'h800, makeOp(Ld, 0, 0, 0), 0, 0, 'h2, 0, 0);
    addRow(Base + 'h800, makeOp(St, 3, 0, 0), 0, 0, 'h1, 0, 0);
    // Flush and stall
    addRow(Base + 'h000, makeOp(St, 3, 0, 0), '1, 'h2, 0, 0, 0);  // FlushW
    addRow(Base + 'h000, makeOp(St, 3, 0, 0), '1, 'h1, 0, 0, 0);  // StallW
    addRow(Base + 'h000, makeOp(Ld, 3, 0, 0), 0, 0, 0, 1, 64'h0123_beef_5aab_cdef);
    addRow(Base + 'h008, makeOp(Ld, 3, 0, 0), 0, 'h1, 0, 1, 64'h0123_beef_5aab_cdef);
    addRow(Base + 'h000, makeOp(Ld, 3, 0, 0), 0, 'h4, 'h2, 0, 0);  // FlushM gives address 0
    addRow(Base + 'h008, makeOp(Ld, 3, 0, 0), 0, 'h8, 'h2, 0, 0);  // StallM keeps address 0
  endtask

  // E cycle then M cycle with fault and address sampled in M and ReadDataW after
  task automatic runAccess(logic [63:0] adr, lsuOpPkg::memOpT op, logic [63:0] wd,
                           logic [3:0] ctl, output lsuOpPkg::lsuFaultT flt,
                           output logic [63:0] adrM, output logic [63:0] rd);
    IEUAdrE = adr;
    MemOpM = '0;
    StallM = ctl[3];
    FlushM = ctl[2];
    StallW = ctl[0];      // Held from E so W keeps the older load
    @(posedge clk);
    #5;
    StallM = 1'b0;
    FlushM = 1'b0;
    IEUAdrE = '0;
    MemOpM = op;
    WriteDataM = wd;
    FlushW = ctl[1];
    #1;
    flt = FaultM;
    adrM = IEUAdrM;
    @(posedge clk);
    #5;
    MemOpM = '0;
    FlushW = 1'b0;
    StallW = 1'b0;
    rd = ReadDataW;
  endtask

  task automatic closeTest(string kind, int idx, int nerr);
    errCount += nerr;
    if (nerr == 0) begin
      passCount++;
      $display("%s %0d passed", kind, idx);
    end else begin
      failCount++;
      $display("%s %0d failed with %0d errors", kind, idx, nerr);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    lsuOpPkg::memOpT    op;
    lsuOpPkg::lsuFaultT flt;
    logic [63:0]        adrM, rd, adr, wd, expRd;
    int                 size, nb, word, lane, idx, rowErr;
    bit                 isStore, be, uns;
    rstN = 1'b0;
    StallM = 1'b0;
    FlushM = 1'b0;
    StallW = 1'b0;
    FlushW = 1'b0;
    IEUAdrE = '0;
    MemOpM = '0;
    WriteDataM = '0;
    buildTable();
    repeat (3) @(posedge clk);
    #5;
    rstN = 1'b1;
    foreach (rows[i]) begin
      runAccess(rows[i].adr, rows[i].op, rows[i].wd, rows[i].ctl, flt, adrM, rd);
      rowErr = 0;
      if (flt !== rows[i].expFault) begin
        $display("Fail at %0t: row %0d fault %b expected %b", $time, i, flt, rows[i].expFault);
        rowErr++;
      end
      // Stalled address keeps the zero left by the previous M cycle
      if (adrM !== ((rows[i].ctl[3] || rows[i].ctl[2]) ? 64'h0 : rows[i].adr)) begin
        $display("Fail at %0t: row %0d IEUAdrM %h", $time, i, adrM);
        rowErr++;
      end
      if (rows[i].chkRd && rd !== rows[i].expRd) begin
        $display("Fail at %0t: row %0d read %h expected %h", $time, i, rd, rows[i].expRd);
        rowErr++;
      end
      closeTest("row", i, rowErr);
    end
    // Known image in words 0 to 7 before random traffic
    for (int w = 0; w < 8; w++) begin
      adr = Base + 64'(w * 8);
      wd = {adr[31:0], adr[63:32]} ^ adr ^ 64'h5a5a_a5a5_5a5a_a5a5;
      runAccess(adr, makeOp(St, 3, 0, 0), wd, 4'b0000, flt, adrM, rd);
      for (int k = 0; k < 8; k++) model[w * 8 + k] = wd[k * 8 +: 8];
    end
    for (int n = 0; n < NumRandom; n++) begin
      seed = xorshift32(seed);
      size = int'(seed[1:0]);
      nb = 1 << size;
      word = int'(seed[4:2]);
      lane = int'(seed[7:5]) / nb * nb;  // Aligned lane
      isStore = seed[8];
      be = seed[9];
      uns = seed[10];
      op = makeOp(isStore ? St : Ld, size, int'(uns), int'(be));
      adr = Base + 64'(word * 8 + lane);
      seed = xorshift32(seed);
      wd[31:0] = seed;
      seed = xorshift32(seed);
      wd[63:32] = seed;
      runAccess(adr, op, wd, 4'b0000, flt, adrM, rd);
      expRd = '0;
      for (int k = 0; k < nb; k++) begin
        idx = word * 8 + (be ? 7 - (lane + k) : lane + k);  // Big-endian mirrors lanes
        if (isStore) model[idx] = wd[k * 8 +: 8];
        else expRd[k * 8 +: 8] = model[idx];
      end
      if (!uns && nb < 8 && expRd[nb * 8 - 1]) expRd = expRd | (~64'h0 << (nb * 8));
      rowErr = 0;
      if (flt !== 4'h0 || (!isStore && rd !== expRd)) begin
        $display("Fail at %0t: random %0d adr %h read %h expected %h fault %b",
                 $time, n, adr, rd, expRd, flt);
        rowErr++;
      end
      closeTest("random", n, rowErr);
    end
    $display("%0d tests passed, %0d tests failed, %0d errors", passCount, failCount, errCount);
    if (errCount == 0) $display("Everything OK");
    else $display("Something failed");
    $finish;
  end

  // Watchdog allows three periods per test plus margin
  initial begin
    longint limit;
    #1;
    limit = longint'(rows.size() + NumRandom + 10) * 3 * Period;
    #(limit);
    $display("Timeout: the run did not finish within %0d time units", limit);
    $display("Something failed");
    $finish;
  end

endmodule

/* verilog.f */
source/lsuCfgPkg.sv
source/lsuOpPkg.sv
source/addrStage.sv
source/storeFormat.sv
source/dtim.sv
source/loadFormat.sv
source/lsu.sv
test/lsu_checker.sv
test/lsuTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --assert --timing -Wno-fatal
TOP      = lsuTb
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Everything OK" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
